// File: common/core_pkg.sv
package core_pkg;

    import rv_pkg::*;

    localparam int ID_W  = 5;
    localparam int PRD_W = 6;

    typedef logic [ID_W-1:0] id_t;     // ROB id
    typedef logic [PRD_W-1:0] prd_t;   // Physical destination

    typedef enum logic [1:0] {
        CSR_WRITE = 2'd0,
        CSR_SET   = 2'd1,
        CSR_CLEAR = 2'd2,
        CSR_READ  = 2'd3
    } csr_op_e;

    // Issued instruction as seen by a functional unit
    typedef struct packed {
        id_t         id;
        xlen_t       pc;
        prd_t        prd;
        csr_op_e     op;
        logic [11:0] imm;      // CSR address
        xlen_t       rs1val;
    } fu_input_t;

    // Result sent to writeback
    typedef struct packed {
        xlen_t pc;
        id_t   id;
        prd_t  prd;
        xlen_t rdval;
    } fu_output_t;

    // Instruction leaving the ROB
    typedef struct packed {
        id_t   id;
        xlen_t pc;
    } rob_entry_t;

endpackage

// File: common/csr_if.sv
`timescale 1ns/1ps

interface csr_if import rv_pkg::*; ();

    // Read port, combinational
    logic      rvalid;
    csr_addr_t raddr;
    xlen_t     rdata;

    // Write port, one-cycle pulse
    logic      wvalid;
    csr_addr_t waddr;
    xlen_t     wdata;

    modport master (
        output rvalid, raddr, wvalid, waddr, wdata,
        input  rdata
    );

    modport slave (
        input  rvalid, raddr, wvalid, waddr, wdata,
        output rdata
    );

endinterface

// File: common/rv_pkg.sv
package rv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;

    // Standard CSR address layout
    typedef struct packed {
        logic [1:0] rw;         // 2'b11 means read-only
        logic [1:0] priv_lvl;
        logic [7:0] index;
    } csr_addr_t;

    localparam logic [1:0] CSR_RW_RO  = 2'b11;
    localparam logic [1:0] PRIV_LVL_M = 2'b11;

    // Machine-mode CSR addresses
    localparam logic [11:0] CSR_MSTATUS  = 12'h300;
    localparam logic [11:0] CSR_MISA     = 12'h301;
    localparam logic [11:0] CSR_MTVEC    = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC     = 12'h341;
    localparam logic [11:0] CSR_MCAUSE   = 12'h342;
    localparam logic [11:0] CSR_MHARTID  = 12'hF14;

    // Only MIE (bit 3) and MPIE (bit 7)
    localparam xlen_t MSTATUS_WMASK = 32'h0000_0088;

    // Alignment bits of mtvec read as zero
    localparam xlen_t MTVEC_WMASK = 32'hFFFF_FFFC;

    // MXL = 1 (32-bit), extension I
    localparam xlen_t MISA_VALUE = 32'h4000_0100;

    localparam xlen_t MHARTID_VALUE = 32'h0000_0000;

endpackage

// File: common/squash_if.sv
`timescale 1ns/1ps

interface squash_if ();

    logic valid;  // One-cycle flush pulse

    modport master (output valid);
    modport slave  (input valid);

endinterface

// File: csr_unit.f
common/rv_pkg.sv
common/core_pkg.sv
common/csr_if.sv
common/squash_if.sv
fu_csr/fu_csr.sv
src/csr_regfile.sv
src/csr_unit.sv
verif/csr_unit_chk.sv
verif/csr_unit_tb.sv

// File: fu_csr/fu_csr.sv
`timescale 1ns/1ps

module fu_csr
    import rv_pkg::*;
    import core_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    // Issue side
    input  fu_input_t  fuinput_i,
    input  logic       fuinput_valid_i,
    output logic       fuinput_ready_o,
    output fu_output_t fuoutput_o,
    output logic       fuoutput_valid_o,
    output logic       completion_valid_o,
    // Retire side
    input  rob_entry_t retire_entry_i,
    input  logic       retire_valid_i,
    csr_if.master      csr_io,
    squash_if.slave    squash_io
);

    // Pending write, held until the instruction retires
    typedef struct packed {
        id_t       id;
        csr_addr_t addr;
        xlen_t     data;
    } csr_wr_entry_t;

    csr_addr_t     csr_addr;
    xlen_t         operand;
    xlen_t         old_val;
    xlen_t         new_val;
    logic          need_write;
    logic          accept;
    logic          buf_load;
    logic          buf_pop;
    logic          buf_valid;
    csr_wr_entry_t buf_q;

    assign csr_addr   = csr_addr_t'(fuinput_i.imm);
    assign operand    = fuinput_i.rs1val;
    assign need_write = fuinput_i.op != CSR_READ;
    assign accept     = fuinput_valid_i && fuinput_ready_o;

    // Early read of the old value
    assign csr_io.rvalid = accept;
    assign csr_io.raddr  = csr_addr;
    assign old_val       = csr_io.rdata;

    always_comb begin
        case (fuinput_i.op)
            CSR_WRITE: new_val = operand;
            CSR_SET:   new_val = old_val | operand;
            CSR_CLEAR: new_val = old_val & ~operand;
            default:   new_val = old_val;  // Read only, never buffered
        endcase
    end

    assign buf_load = accept && need_write;
    assign buf_pop  = buf_valid && retire_valid_i && (retire_entry_i.id == buf_q.id);

    // Valid bit of the write buffer
    always_ff @(posedge clk) begin
        if (!rstn) begin
            buf_valid <= 1'b0;
        end else if (squash_io.valid) begin
            buf_valid <= 1'b0;  // Squash wins over a load
        end else if (buf_load) begin
            buf_valid <= 1'b1;
        end else if (buf_pop) begin
            buf_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (buf_load) begin
            buf_q.id   <= fuinput_i.id;
            buf_q.addr <= csr_addr;
            buf_q.data <= new_val;
        end
    end

    // Commit the buffered write
    assign csr_io.wvalid = buf_pop;
    assign csr_io.waddr  = buf_q.addr;
    assign csr_io.wdata  = buf_q.data;

    // Result carries the value before the instruction
    assign fuoutput_o.pc    = fuinput_i.pc;
    assign fuoutput_o.id    = fuinput_i.id;
    assign fuoutput_o.prd   = fuinput_i.prd;
    assign fuoutput_o.rdval = old_val;
    assign fuoutput_valid_o   = accept;
    assign completion_valid_o = accept;

    // One CSR write in flight at a time
    assign fuinput_ready_o = !buf_valid;

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f csr_unit.f --top-module csr_unit_tb -o csr_unit_sim &&
./obj_dir/csr_unit_sim | grep -F '*** PASSED ***' &&
echo "Simulation passed" && exit 0 ||
{ echo "Simulation failed"; exit 1; }

// File: src/csr_regfile.sv
`timescale 1ns/1ps

module csr_regfile
    import rv_pkg::*;
(
    input  logic clk,
    input  logic rstn,
    csr_if.slave csr_io
);

    xlen_t       mstatus_q;
    xlen_t       mscratch_q;
    xlen_t       mtvec_q;
    xlen_t       mepc_q;
    xlen_t       mcause_q;
    xlen_t       rd_val;
    logic [11:0] raddr;
    logic [11:0] waddr;
    logic        wr_en;

    assign raddr = csr_io.raddr;
    assign waddr = csr_io.waddr;

    // Read-only space and non-machine addresses take no writes
    assign wr_en = csr_io.wvalid
                && (csr_io.waddr.rw != CSR_RW_RO)
                && (csr_io.waddr.priv_lvl == PRIV_LVL_M);

    // Read decode
    always_comb begin
        case (raddr)
            CSR_MSTATUS:  rd_val = mstatus_q;
            CSR_MISA:     rd_val = MISA_VALUE;
            CSR_MTVEC:    rd_val = mtvec_q;
            CSR_MSCRATCH: rd_val = mscratch_q;
            CSR_MEPC:     rd_val = mepc_q;
            CSR_MCAUSE:   rd_val = mcause_q;
            CSR_MHARTID:  rd_val = MHARTID_VALUE;
            default:      rd_val = '0;  // Unknown CSR
        endcase
    end

    assign csr_io.rdata = csr_io.rvalid ? rd_val : '0;

    // Write decode
    always_ff @(posedge clk) begin
        if (!rstn) begin
            mstatus_q  <= '0;
            mscratch_q <= '0;
            mtvec_q    <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
        end else if (wr_en) begin
            case (waddr)
                CSR_MSTATUS:  mstatus_q  <= csr_io.wdata & MSTATUS_WMASK;
                CSR_MTVEC:    mtvec_q    <= csr_io.wdata & MTVEC_WMASK;
                CSR_MSCRATCH: mscratch_q <= csr_io.wdata;
                CSR_MEPC:     mepc_q     <= csr_io.wdata;
                CSR_MCAUSE:   mcause_q   <= csr_io.wdata;
                default: ;  // misa and unknown CSRs drop the write
            endcase
        end
    end

endmodule

// File: src/csr_unit.sv
`timescale 1ns/1ps

module csr_unit
    import core_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  fu_input_t  fuinput_i,
    input  logic       fuinput_valid_i,
    output logic       fuinput_ready_o,
    output fu_output_t fuoutput_o,
    output logic       fuoutput_valid_o,
    output logic       completion_valid_o,
    input  rob_entry_t retire_entry_i,
    input  logic       retire_valid_i,
    input  logic       squash_i
);

    csr_if    csr_bus ();
    squash_if squash_bus ();

    assign squash_bus.valid = squash_i;  // Pipeline flush pulse

    fu_csr u_fu_csr (
        .clk                (clk),
        .rstn               (rstn),
        .fuinput_i          (fuinput_i),
        .fuinput_valid_i    (fuinput_valid_i),
        .fuinput_ready_o    (fuinput_ready_o),
        .fuoutput_o         (fuoutput_o),
        .fuoutput_valid_o   (fuoutput_valid_o),
        .completion_valid_o (completion_valid_o),
        .retire_entry_i     (retire_entry_i),
        .retire_valid_i     (retire_valid_i),
        .csr_io             (csr_bus.master),
        .squash_io          (squash_bus.slave)
    );

    // Machine-mode CSR storage
    csr_regfile u_csr_regfile (
        .clk    (clk),
        .rstn   (rstn),
        .csr_io (csr_bus.slave)
    );

endmodule

// File: verif/csr_unit_chk.sv
`timescale 1ns/1ps

module csr_unit_chk
    import core_pkg::*;
(
    input logic clk,
    input logic rstn,
    input logic ready_i,
    input logic fuinput_valid_i,
    input id_t  issue_id_i,
    input logic write_op_i,
    input logic squash_i,
    input logic retire_valid_i,
    input id_t  retire_id_i,
    input logic wvalid_i
);

    // Own record of the write in flight
    logic pend_valid;
    id_t  pend_id;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pend_valid <= 1'b0;
        end else if (squash_i) begin
            pend_valid <= 1'b0;
        end else if (fuinput_valid_i && ready_i && write_op_i) begin
            pend_valid <= 1'b1;
        end else if (retire_valid_i && retire_id_i == pend_id) begin
            pend_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fuinput_valid_i && ready_i && write_op_i) begin
            pend_id <= issue_id_i;  // Id of the accepted write
        end
    end

    // Buffer comes out of reset empty
    property ready_after_reset_p;
        @(posedge clk) !rstn |=> ready_i;
    endproperty

    // Only the matching retire releases the write
    property wvalid_on_match_p;
        @(posedge clk) disable iff (!rstn)
            wvalid_i |-> (pend_valid && retire_valid_i && retire_id_i == pend_id);
    endproperty

    property ready_low_after_write_p;
        @(posedge clk) disable iff (!rstn)
            (fuinput_valid_i && ready_i && write_op_i && !squash_i) |=> !ready_i;
    endproperty

    ready_after_reset_a: assert property (ready_after_reset_p)
        else $error("ready low in the cycle after reset");
    wvalid_on_match_a: assert property (wvalid_on_match_p)
        else $error("CSR write without a matching retire");
    ready_low_after_write_a: assert property (ready_low_after_write_p)
        else $error("ready high after an accepted write");

endmodule

bind fu_csr csr_unit_chk u_csr_unit_chk (
    .clk             (clk),
    .rstn            (rstn),
    .ready_i         (fuinput_ready_o),
    .fuinput_valid_i (fuinput_valid_i),
    .issue_id_i      (fuinput_i.id),
    .write_op_i      (need_write),
    .squash_i        (squash_io.valid),
    .retire_valid_i  (retire_valid_i),
    .retire_id_i     (retire_entry_i.id),
    .wvalid_i        (csr_io.wvalid)
);

// File: verif/csr_unit_golden.txt
# name op(0 write,1 set,2 clear,3 read) addr(hex) operand(hex) action expected_rdval(hex)
# action: 0 retire, 1 squash, 2 retire with a wrong id and then the right id
wr_mscratch    0 340 deadbeef 0 00000000
rd_mscratch    3 340 00000000 0 deadbeef
set_mtvec      1 305 00001003 0 00000000
rd_mtvec       3 305 00000000 0 00001000
set_mtvec_2    1 305 000000f0 0 00001000
clr_mtvec      2 305 00001000 0 000010f0
rd_mtvec_2     3 305 00000000 0 000000f0
set_mepc       1 341 12345678 0 00000000
clr_mepc       2 341 0000ffff 0 12345678
rd_mepc        3 341 00000000 0 12340000
sq_mscratch    0 340 11111111 1 deadbeef
rd_mscratch_2  3 340 00000000 0 deadbeef
wrongid_mcause 0 342 0000000b 2 00000000
rd_mcause      3 342 00000000 0 0000000b
wr_mstatus     0 300 ffffffff 0 00000000
rd_mstatus     3 300 00000000 0 00000088
clr_mstatus    2 300 00000008 0 00000088
rd_mstatus_2   3 300 00000000 0 00000080
wr_misa        0 301 00000000 0 40000100
rd_misa        3 301 00000000 0 40000100
wr_mhartid     0 f14 ffffffff 0 00000000
rd_mhartid     3 f14 00000000 0 00000000
wr_unknown     0 7c0 ffffffff 0 00000000
rd_unknown     3 7c0 00000000 0 00000000

// File: verif/csr_unit_tb.sv
`timescale 1ns/1ps

module csr_unit_tb
    import rv_pkg::*;
    import core_pkg::*;
();

    localparam int HALF_PERIOD = 50;
    localparam int MAX_TESTS   = 64;
    localparam int NAME_W      = 8 * 24;

    logic       clk;
    logic       rstn;
    fu_input_t  fuinput;
    logic       fuinput_valid;
    logic       fuinput_ready;
    fu_output_t fuoutput;
    logic       fuoutput_valid;
    logic       completion_valid;
    rob_entry_t retire_entry;
    logic       retire_valid;
    logic       squash;

    // One entry per golden line
    logic [NAME_W-1:0] test_name    [MAX_TESTS];
    logic [1:0]        test_op      [MAX_TESTS];
    logic [11:0]       test_addr    [MAX_TESTS];
    xlen_t             test_operand [MAX_TESTS];
    logic [1:0]        test_action  [MAX_TESTS];  // 0 retire, 1 squash, 2 wrong id first
    xlen_t             test_expect  [MAX_TESTS];

    int     num_tests;
    int     pass_cnt;
    int     fail_cnt;
    int     cycle_cnt = 0;
    int     timeout_limit = 50;
    integer seed;
    id_t    next_id;
    logic   golden_ok;

    csr_unit dut (
        .clk                (clk),
        .rstn               (rstn),
        .fuinput_i          (fuinput),
        .fuinput_valid_i    (fuinput_valid),
        .fuinput_ready_o    (fuinput_ready),
        .fuoutput_o         (fuoutput),
        .fuoutput_valid_o   (fuoutput_valid),
        .completion_valid_o (completion_valid),
        .retire_entry_i     (retire_entry),
        .retire_valid_i     (retire_valid),
        .squash_i           (squash)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Run limit scales with the number of golden lines
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic load_golden(output logic ok);
        integer            fd;
        integer            r;
        string             line;
        logic [NAME_W-1:0] name;
        logic [31:0]       op_val;
        logic [31:0]       addr_val;
        logic [31:0]       operand_val;
        logic [31:0]       action_val;
        logic [31:0]       expect_val;
        num_tests = 0;
        fd = $fopen("verif/csr_unit_golden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open verif/csr_unit_golden.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                r = $sscanf(line, "%s %d %h %h %d %h", name, op_val, addr_val,
                            operand_val, action_val, expect_val);
                if (line.getc(0) != 8'h23 && r == 6 && num_tests < MAX_TESTS) begin
                    test_name[num_tests]    = name;
                    test_op[num_tests]      = op_val[1:0];
                    test_addr[num_tests]    = addr_val[11:0];
                    test_operand[num_tests] = operand_val;
                    test_action[num_tests]  = action_val[1:0];
                    test_expect[num_tests]  = expect_val;
                    num_tests = num_tests + 1;
                end
            end
            $fclose(fd);
        end
        ok = (num_tests > 0);
    endtask

    task automatic apply_reset();
        rstn = 1'b0;
        repeat (5) @(negedge clk);
        rstn = 1'b1;
    endtask

    // One-cycle retire pulse
    task automatic retire(input id_t rid, input xlen_t pc);
        retire_entry.id = rid;
        retire_entry.pc = pc;
        retire_valid    = 1'b1;
        @(negedge clk);
        retire_valid    = 1'b0;
    endtask

    task automatic run_test(input int idx);
        fu_input_t instr;
        xlen_t     rnd;
        xlen_t     actual;
        id_t       id;
        logic      value_ok;
        logic      other_ok;
        value_ok = 1'b1;
        other_ok = 1'b1;
        while (!fuinput_ready) @(negedge clk);
        id      = next_id;
        next_id = next_id + 1'b1;
        rnd     = $random(seed);
        instr.id     = id;
        instr.pc     = {rnd[31:2], 2'b00};
        instr.prd    = rnd[5:0];
        instr.op     = csr_op_e'(test_op[idx]);
        instr.imm    = test_addr[idx];
        instr.rs1val = test_operand[idx];
        fuinput       = instr;
        fuinput_valid = 1'b1;
        #(HALF_PERIOD / 2);
        actual = fuoutput.rdval;
        if (actual !== test_expect[idx]) value_ok = 1'b0;
        if (fuoutput_valid !== 1'b1 || completion_valid !== 1'b1) begin
            $display("%0s: result valid did not rise with the accepted input", test_name[idx]);
            other_ok = 1'b0;
        end
        if (fuoutput.id !== id) begin
            $display("%0s: result carries id %0d instead of %0d", test_name[idx],
                     fuoutput.id, id);
            other_ok = 1'b0;
        end
        if (fuoutput.pc !== instr.pc || fuoutput.prd !== instr.prd) begin
            $display("%0s: result pc or prd does not match the issued instruction",
                     test_name[idx]);
            other_ok = 1'b0;
        end
        @(negedge clk);
        fuinput_valid = 1'b0;
        case (test_action[idx])
            2'd0: retire(id, instr.pc);
            2'd1: begin
                squash = 1'b1;
                @(negedge clk);
                squash = 1'b0;
                if (fuinput_ready !== 1'b1) begin
                    $display("%0s: ready stayed low after the squash", test_name[idx]);
                    other_ok = 1'b0;
                end
            end
            2'd2: begin
                retire(id + 1'b1, instr.pc);  // Some other instruction
                if (test_op[idx] != CSR_READ && fuinput_ready !== 1'b0) begin
                    $display("%0s: retire with a wrong id released the write",
                             test_name[idx]);
                    other_ok = 1'b0;
                end
                retire(id, instr.pc);
            end
            default: ;
        endcase
        if (!value_ok) begin
            $display("FAILED %0s: expected %08h, actual %08h", test_name[idx],
                     test_expect[idx], actual);
            fail_cnt = fail_cnt + 1;
        end else if (!other_ok) begin
            $display("Test %0s failed a handshake check", test_name[idx]);
            fail_cnt = fail_cnt + 1;
        end else begin
            $display("ok %0s: rdval %08h", test_name[idx], actual);
            pass_cnt = pass_cnt + 1;
        end
    endtask

    initial begin
        seed          = 32'h5935_3e4c;
        rstn          = 1'b0;
        fuinput       = '0;
        fuinput_valid = 1'b0;
        retire_entry  = '0;
        retire_valid  = 1'b0;
        squash        = 1'b0;
        pass_cnt      = 0;
        fail_cnt      = 0;
        next_id       = '0;
        load_golden(golden_ok);
        timeout_limit = 20 * num_tests + 50;
        if (!golden_ok) begin
            $display("No usable test lines in verif/csr_unit_golden.txt");
            $display("*** FAILED ***");
            $finish;
        end else begin
            apply_reset();
            for (int i = 0; i < num_tests; i++) begin
                run_test(i);
            end
            $display("Tests: %0d run, %0d passed, %0d failed", num_tests, pass_cnt, fail_cnt);
            if (fail_cnt == 0) begin
                $display("*** PASSED ***");
            end else begin
                $display("*** FAILED ***");
            end
            $finish;
        end
    end

endmodule
